// File: build.f
+incdir+sim
common/core_pkg.sv
common/lsu_pkg.sv
common/sb_if.sv
store_buffer/store_buffer.sv
src/lsu_ctrl.sv
src/load_align.sv
src/data_ram.sv
src/lsu_top.sv
sim/tb_lsu.sv

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

    // Instruction tag where a larger value marks an older instruction
    localparam int TAG_W = 32;

    // Physical destination register index
    localparam int PHY_W = 8;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [PHY_W-1:0] phy_t;

endpackage

`default_nettype wire

// File: common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int XLEN   = 32;
    localparam int ADDR_W = 16;    // Byte address
    localparam int WADDR_W = ADDR_W - 2;

    localparam int SB_DEPTH = 8;
    localparam int SB_IDX_W = 3;

    localparam int LANES = XLEN / 8;

    // RISC-V load/store funct3
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_BU = 3'b100,
        F3_HU = 3'b101
    } funct3_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [LANES-1:0]   mask_t;
    typedef logic [WADDR_W-1:0] waddr_t;

endpackage

`default_nettype wire

// File: common/sb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sb_if;
    import lsu_pkg::*;
    import core_pkg::*;

    // One-cycle allocation pulse for a new store
    logic   alloc;
    waddr_t alloc_waddr;
    mask_t  alloc_mask;
    word_t  alloc_data;
    tag_t   alloc_tag;

    waddr_t look_waddr;    // Word under load
    logic   full;
    mask_t  look_mask;     // Registered merge result
    word_t  look_data;

    modport ctrl (
        output alloc, alloc_waddr, alloc_mask, alloc_data, alloc_tag, look_waddr,
        input  full
    );

    modport buffer (
        input  alloc, alloc_waddr, alloc_mask, alloc_data, alloc_tag, look_waddr,
        output full, look_mask, look_data
    );

endinterface

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_lsu -Mdir obj_dir -o tb_lsu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_word   = 0;
int err_phy    = 0;
int err_tag    = 0;
int err_flag   = 0;
int err_cycles = 0;

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
        err_word++;
        $display("[FAIL] %s: expected %08h, actual %08h", name, exp, act);
    end
endtask

task automatic check_phy(input string name, input phy_t exp, input phy_t act);
    if (exp !== act) begin
        err_phy++;
        $display("[FAIL] %s: expected phy %02h, actual %02h", name, exp, act);
    end
endtask

task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (exp !== act) begin
        err_tag++;
        $display("[FAIL] %s: expected tag %08h, actual %08h", name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        err_flag++;
        $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
    end
endtask

// Clock cycles from req sampled to ack seen
task automatic check_cycles(input string name, input int exp, input int act);
    if (exp != act) begin
        err_cycles++;
        $display("[FAIL] %s: expected %0d cycles, actual %0d", name, exp, act);
    end
endtask

function automatic int error_total();
    return err_word + err_phy + err_tag + err_flag + err_cycles;
endfunction

task automatic report_errors();
    $display("Errors: data %0d, phy %0d, tag %0d, flag %0d, latency %0d, total %0d",
             err_word, err_phy, err_tag, err_flag, err_cycles, error_total());
endtask

`endif

// File: sim/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;
    import core_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_RAND       = 12;    // Committed random stores
    localparam int N_LOADS      = 15;
    localparam int N_REQS       = N_RAND + N_LOADS + 8 + 7 + (SB_DEPTH + 3) + 4 + 1;

    logic              clk = 1'b0;
    logic              reset;
    logic              req;
    logic              commit;
    logic              flush;
    logic              ack;
    logic              fault;
    mem_op_e           op;
    funct3_e           funct3;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;
    word_t             rdata;
    tag_t              tag;
    tag_t              rd_tag;
    phy_t              phy;
    phy_t              rd_phy;

    logic [31:0] lfsr     = 32'hfcee_8177;
    tag_t        next_tag = '1;    // Counts down so younger tags are smaller

    typedef struct packed {
        waddr_t waddr;
        mask_t  mask;
        word_t  data;
    } pend_t;

    word_t model_mem [waddr_t];
    pend_t pending [$];    // Uncommitted stores with the oldest first

    `include "tb_checks.svh"

    lsu_top DUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic logic is_misaligned(input funct3_e f3, input logic [ADDR_W-1:0] a);
        return ((f3 == F3_H || f3 == F3_HU) && a[0]) || (f3 == F3_W && a[1:0] != 2'b00);
    endfunction

    function automatic funct3_e store_width();
        logic [31:0] r;
        r = rand_bits(2);
        case (r[1:0])
            2'd0:    return F3_B;
            2'd1:    return F3_H;
            default: return F3_W;
        endcase
    endfunction

    function automatic funct3_e load_width(input int k);
        case (k % 5)
            0:       return F3_B;
            1:       return F3_H;
            2:       return F3_W;
            3:       return F3_BU;
            default: return F3_HU;
        endcase
    endfunction

    // Random aligned address inside a window of 2**span bytes
    function automatic logic [ADDR_W-1:0] rand_addr(input logic [ADDR_W-1:0] base,
                                                    input int span, input funct3_e f3);
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        r = rand_bits(span);
        a = base | r[ADDR_W-1:0];
        if (f3 == F3_H || f3 == F3_HU) a[0] = 1'b0;
        if (f3 == F3_W) a[1:0] = 2'b00;
        return a;
    endfunction

    function automatic pend_t model_store(input funct3_e f3, input logic [ADDR_W-1:0] a,
                                          input word_t d);
        pend_t p;
        int    size;
        size    = (f3 == F3_W) ? 4 : (f3 == F3_H) ? 2 : 1;
        p.waddr = a[ADDR_W-1:2];
        p.mask  = '0;
        p.data  = '0;
        for (int k = 0; k < size; k++) begin
            p.mask[a[1:0] + k]          = 1'b1;
            p.data[8*(a[1:0] + k) +: 8] = d[8*k +: 8];
        end
        return p;
    endfunction

    function automatic word_t merge_lanes(input word_t base, input pend_t p);
        for (int b = 0; b < LANES; b++) begin
            if (p.mask[b]) base[8*b +: 8] = p.data[8*b +: 8];
        end
        return base;
    endfunction

    // Memory word with pending stores laid over it in age order
    function automatic word_t model_word(input waddr_t wa);
        word_t w;
        w = model_mem.exists(wa) ? model_mem[wa] : '0;
        foreach (pending[i]) begin
            if (pending[i].waddr == wa) w = merge_lanes(w, pending[i]);
        end
        return w;
    endfunction

    function automatic word_t expect_load(input funct3_e f3, input logic [ADDR_W-1:0] a);
        word_t w;
        int    sh;
        w  = model_word(a[ADDR_W-1:2]);
        sh = 8 * a[1:0];
        case (f3)
            F3_B:    return $signed(w << (24 - sh)) >>> 24;
            F3_BU:   return (w << (24 - sh)) >> 24;
            F3_H:    return $signed(w << (16 - sh)) >>> 16;
            F3_HU:   return (w << (16 - sh)) >> 16;
            default: return w;
        endcase
    endfunction

    task automatic start_req(input mem_op_e o, input funct3_e f3,
                             input logic [ADDR_W-1:0] a, input word_t d);
        logic [31:0] r;
        r      = rand_bits(PHY_W);
        op     = o;
        funct3 = f3;
        addr   = a;
        wdata  = d;
        tag    = next_tag;
        phy    = r[PHY_W-1:0];
        next_tag--;
        req    = 1'b1;
    endtask

    task automatic wait_ack(output int cycles);
        cycles = 0;
        while (!ack) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic end_req();
        req = 1'b0;
        while (ack) @(negedge clk);
    endtask

    task automatic pulse_commit();
        commit = 1'b1;
        @(negedge clk);
        commit = 1'b0;
        if (pending.size() != 0) begin
            model_mem[pending[0].waddr] = merge_lanes(model_word_committed(pending[0].waddr),
                                                      pending[0]);
            void'(pending.pop_front());
        end
    endtask

    function automatic word_t model_word_committed(input waddr_t wa);
        return model_mem.exists(wa) ? model_mem[wa] : '0;
    endfunction

    task automatic do_store(input string name, input funct3_e f3,
                            input logic [ADDR_W-1:0] a, input word_t d);
        int   cycles;
        logic mis;
        mis = is_misaligned(f3, a);
        start_req(OP_STORE, f3, a, d);
        wait_ack(cycles);
        check_cycles(name, mis ? 1 : 2, cycles - 1);
        check_flag({name, " fault"}, mis, fault);
        if (!mis) pending.push_back(model_store(f3, a, d));
        end_req();
    endtask

    task automatic do_load(input string name, input funct3_e f3, input logic [ADDR_W-1:0] a);
        int    cycles;
        logic  mis;
        word_t exp;
        phy_t  exp_phy;
        tag_t  exp_tag;
        mis = is_misaligned(f3, a);
        exp = expect_load(f3, a);
        start_req(OP_LOAD, f3, a, rand_bits(32));
        exp_phy = phy;
        exp_tag = tag;
        wait_ack(cycles);
        check_cycles(name, mis ? 1 : 3, cycles - 1);
        check_flag({name, " fault"}, mis, fault);
        if (!mis) begin
            check_word(name, exp, rdata);
            check_phy(name, exp_phy, rd_phy);
            check_tag(name, exp_tag, rd_tag);
        end
        end_req();
    endtask

    task automatic committed_stores_then_loads();
        funct3_e f3;
        for (int i = 0; i < N_RAND; i++) begin
            f3 = store_width();
            do_store("committed store", f3, rand_addr(16'h0040, 5, f3), rand_bits(32));
            pulse_commit();
        end
        for (int i = 0; i < N_LOADS; i++) begin
            f3 = load_width(i);
            do_load("committed load", f3, rand_addr(16'h0040, 5, f3));
        end
    endtask

    task automatic forwarding_before_commit();
        do_store("fwd base word", F3_W, 16'h0100, rand_bits(32));
        pulse_commit();
        do_store("fwd half", F3_H, 16'h0100, rand_bits(32));
        do_store("fwd byte", F3_B, 16'h0101, rand_bits(32));
        do_store("fwd other word", F3_W, 16'h0104, rand_bits(32));
        do_store("fwd top byte", F3_B, 16'h0103, rand_bits(32));
        do_load("fwd LW", F3_W, 16'h0100);
        do_load("fwd LH", F3_H, 16'h0100);
        do_load("fwd LBU", F3_BU, 16'h0103);
        while (pending.size() != 0) pulse_commit();
    endtask

    task automatic flush_discards_stores();
        do_store("flush kept word", F3_W, 16'h0140, rand_bits(32));
        pulse_commit();
        do_store("flush word", F3_W, 16'h0140, rand_bits(32));
        do_store("flush byte", F3_B, 16'h0101, rand_bits(32));
        do_store("flush half", F3_H, 16'h0146, rand_bits(32));
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        pending.delete();
        do_load("after flush LW", F3_W, 16'h0140);
        do_load("after flush LB", F3_B, 16'h0101);
        do_load("after flush LHU", F3_HU, 16'h0146);
    endtask

    task automatic backpressure_when_full();
        int                cycles;
        funct3_e           f3;
        logic [ADDR_W-1:0] a;
        word_t             d;
        for (int i = 0; i < SB_DEPTH; i++) begin
            f3 = store_width();
            do_store("fill store", f3, rand_addr(16'h0200, 3, f3), rand_bits(32));
        end
        f3 = store_width();
        a  = rand_addr(16'h0200, 3, f3);
        d  = rand_bits(32);
        start_req(OP_STORE, f3, a, d);
        repeat (6) begin
            @(negedge clk);
            check_flag("ack while full", 1'b0, ack);
        end
        pulse_commit();
        wait_ack(cycles);
        check_cycles("ack after commit", 1, cycles);
        check_flag("stalled store fault", 1'b0, fault);
        pending.push_back(model_store(f3, a, d));
        end_req();
        while (pending.size() != 0) pulse_commit();
        do_load("drained LW 0", F3_W, 16'h0200);
        do_load("drained LW 1", F3_W, 16'h0204);
    endtask

    task automatic misaligned_faults();
        do_store("misalign base", F3_W, 16'h0300, rand_bits(32));
        pulse_commit();
        do_load("LH odd address", F3_H, 16'h0301);
        do_store("SW offset 2", F3_W, 16'h0302, rand_bits(32));
        pulse_commit();    // Empty buffer, nothing to drain
        do_load("load after faults", F3_W, 16'h0300);
    endtask

    initial begin
        reset  = 1'b1;
        req    = 1'b0;
        commit = 1'b0;
        flush  = 1'b0;
        op     = OP_LOAD;
        funct3 = F3_W;
        addr   = '0;
        wdata  = '0;
        tag    = '0;
        phy    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        committed_stores_then_loads();
        forwarding_before_commit();
        flush_discards_stores();
        backpressure_when_full();
        misaligned_faults();
        do_load("load latency", F3_W, 16'h0044);
        report_errors();
        if (error_total() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (N_REQS * 20 + RESET_CYCLES) @(posedge clk);
        $display("Timeout: tests did not complete within %0d cycles", N_REQS * 20 + RESET_CYCLES);
        report_errors();
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  logic            clk,
    input  logic            reset,
    input  logic            wr_en,
    input  lsu_pkg::waddr_t wr_waddr,
    input  lsu_pkg::mask_t  wr_mask,
    input  lsu_pkg::word_t  wr_data,
    input  lsu_pkg::waddr_t rd_waddr,
    output lsu_pkg::word_t  rd_data
);
    import lsu_pkg::*;

    localparam int WORDS = 2 ** WADDR_W;

    word_t mem [WORDS] = '{default: '0};    // Starts cleared

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < LANES; b++) begin
                if (wr_mask[b]) mem[wr_waddr][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    // Read returns the word as it was before a same-edge write
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_waddr];
        end
    end

endmodule

`default_nettype wire

// File: src/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  logic             clk,
    input  logic             reset,
    input  lsu_pkg::word_t   ram_data,
    input  lsu_pkg::mask_t   fwd_mask,
    input  lsu_pkg::word_t   fwd_data,
    input  lsu_pkg::funct3_e ld_funct3,
    input  logic [1:0]       ld_byte_off,
    output lsu_pkg::word_t   rdata
);
    import lsu_pkg::*;

    word_t       merged;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Buffered lanes override memory
    always_comb begin
        for (int b = 0; b < LANES; b++) begin
            merged[8*b +: 8] = fwd_mask[b] ? fwd_data[8*b +: 8] : ram_data[8*b +: 8];
        end
    end

    assign sel_byte = merged[8*ld_byte_off +: 8];
    assign sel_half = merged[16*ld_byte_off[1] +: 16];

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else begin
            case (ld_funct3)
                F3_B:    rdata <= {{24{sel_byte[7]}}, sel_byte};
                F3_BU:   rdata <= {24'd0, sel_byte};
                F3_H:    rdata <= {{16{sel_half[15]}}, sel_half};
                F3_HU:   rdata <= {16'd0, sel_half};
                default: rdata <= merged;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req,
    input  lsu_pkg::mem_op_e           op,
    input  lsu_pkg::funct3_e           funct3,
    input  logic [lsu_pkg::ADDR_W-1:0] addr,
    input  lsu_pkg::word_t             wdata,
    input  core_pkg::tag_t             tag,
    input  core_pkg::phy_t             phy,
    output logic                       ack,
    output logic                       fault,
    output core_pkg::phy_t             rd_phy,
    output core_pkg::tag_t             rd_tag,
    output lsu_pkg::funct3_e           ld_funct3,
    output logic [1:0]                 ld_byte_off,
    output lsu_pkg::waddr_t            rd_waddr,
    sb_if.ctrl                         sb
);
    import lsu_pkg::*;
    import core_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        CAPTURE,
        STORE_WAIT,
        LOAD_READ,
        LOAD_ALIGN,
        RESP,
        RELEASE
    } state_e;

    state_e state;

    // Request fields held for the whole transaction
    mem_op_e             cap_op;
    funct3_e             cap_f3;
    logic [ADDR_W-1:0]   cap_addr;
    word_t               cap_wdata;
    tag_t                cap_tag;
    phy_t                cap_phy;

    logic  misaligned;
    mask_t base_mask;
    mask_t st_mask;
    word_t st_data;

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            cap_op    <= op;
            cap_f3    <= funct3;
            cap_addr  <= addr;
            cap_wdata <= wdata;
            cap_tag   <= tag;
            cap_phy   <= phy;
        end
    end

    always_comb begin
        case (cap_f3)
            F3_B, F3_BU: misaligned = 1'b0;
            F3_H, F3_HU: misaligned = cap_addr[0];
            F3_W:        misaligned = |cap_addr[1:0];
            default:     misaligned = 1'b1;    // Unknown width
        endcase
    end

    // Store lanes within the word
    always_comb begin
        case (cap_f3)
            F3_B, F3_BU: base_mask = 4'b0001;
            F3_H, F3_HU: base_mask = 4'b0011;
            default:     base_mask = 4'b1111;
        endcase
        st_mask = base_mask << cap_addr[1:0];
        st_data = cap_wdata << {cap_addr[1:0], 3'b000};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            ack   <= 1'b0;
            fault <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) state <= CAPTURE;
                end
                CAPTURE: begin
                    if (misaligned) begin
                        ack   <= 1'b1;
                        fault <= 1'b1;
                        state <= RESP;
                    end else if (cap_op == OP_STORE) begin
                        state <= STORE_WAIT;
                    end else begin
                        state <= LOAD_READ;    // RAM read and lookup on this edge
                    end
                end
                STORE_WAIT: begin
                    if (!sb.full) begin    // Alloc pulses on this edge
                        ack   <= 1'b1;
                        state <= RESP;
                    end
                end
                LOAD_READ:  state <= LOAD_ALIGN;
                LOAD_ALIGN: begin
                    ack   <= 1'b1;
                    state <= RESP;
                end
                RESP: begin
                    if (!req) state <= RELEASE;
                end
                RELEASE: begin
                    ack   <= 1'b0;
                    fault <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign sb.alloc       = (state == STORE_WAIT) && !sb.full;
    assign sb.alloc_waddr = cap_addr[ADDR_W-1:2];
    assign sb.alloc_mask  = st_mask;
    assign sb.alloc_data  = st_data;
    assign sb.alloc_tag   = cap_tag;
    assign sb.look_waddr  = cap_addr[ADDR_W-1:2];

    assign rd_waddr    = cap_addr[ADDR_W-1:2];
    assign rd_phy      = cap_phy;
    assign rd_tag      = cap_tag;
    assign ld_funct3   = cap_f3;
    assign ld_byte_off = cap_addr[1:0];

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req,
    input  lsu_pkg::mem_op_e           op,
    input  lsu_pkg::funct3_e           funct3,
    input  logic [lsu_pkg::ADDR_W-1:0] addr,
    input  lsu_pkg::word_t             wdata,
    input  core_pkg::tag_t             tag,
    input  core_pkg::phy_t             phy,
    output logic                       ack,
    output lsu_pkg::word_t             rdata,
    output core_pkg::phy_t             rd_phy,
    output core_pkg::tag_t             rd_tag,
    output logic                       fault,
    input  logic                       commit,
    input  logic                       flush
);
    import lsu_pkg::*;

    sb_if sb ();

    waddr_t     rd_waddr;
    word_t      ram_rdata;
    logic       wr_en;
    waddr_t     wr_waddr;
    mask_t      wr_mask;
    word_t      wr_data;
    funct3_e    ld_funct3;
    logic [1:0] ld_byte_off;

    lsu_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op          (op),
        .funct3      (funct3),
        .addr        (addr),
        .wdata       (wdata),
        .tag         (tag),
        .phy         (phy),
        .ack         (ack),
        .fault       (fault),
        .rd_phy      (rd_phy),
        .rd_tag      (rd_tag),
        .ld_funct3   (ld_funct3),
        .ld_byte_off (ld_byte_off),
        .rd_waddr    (rd_waddr),
        .sb          (sb.ctrl)
    );

    store_buffer u_sb (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit),
        .flush    (flush),
        .sb       (sb.buffer),
        .wr_en    (wr_en),
        .wr_waddr (wr_waddr),
        .wr_mask  (wr_mask),
        .wr_data  (wr_data)
    );

    data_ram u_ram (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_waddr (wr_waddr),
        .wr_mask  (wr_mask),
        .wr_data  (wr_data),
        .rd_waddr (rd_waddr),
        .rd_data  (ram_rdata)
    );

    load_align u_align (
        .clk         (clk),
        .reset       (reset),
        .ram_data    (ram_rdata),
        .fwd_mask    (sb.look_mask),
        .fwd_data    (sb.look_data),
        .ld_funct3   (ld_funct3),
        .ld_byte_off (ld_byte_off),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

// File: store_buffer/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module store_buffer (
    input  logic            clk,
    input  logic            reset,
    input  logic            commit,
    input  logic            flush,
    sb_if.buffer            sb,
    output logic            wr_en,
    output lsu_pkg::waddr_t wr_waddr,
    output lsu_pkg::mask_t  wr_mask,
    output lsu_pkg::word_t  wr_data
);
    import lsu_pkg::*;
    import core_pkg::*;

    // Entry storage
    waddr_t e_waddr [SB_DEPTH];
    mask_t  e_mask  [SB_DEPTH];
    word_t  e_data  [SB_DEPTH];
    tag_t   e_tag   [SB_DEPTH];

    logic [SB_DEPTH-1:0] valid;
    logic [SB_IDX_W-1:0] head;    // Oldest entry
    logic [SB_IDX_W-1:0] tail;    // Next free slot

    logic push;
    logic pop;

    // Lookup walk
    logic [SB_IDX_W-1:0] walk_idx;
    tag_t                lane_tag [LANES];
    mask_t               mrg_mask;
    word_t               mrg_data;

    // Ring is full when the slot at the tail is still occupied
    assign sb.full = valid[tail];

    assign push = sb.alloc && !valid[tail];
    assign pop  = commit && valid[head];    // Empty commit ignored

    // Drain port into data memory
    assign wr_en    = pop;
    assign wr_waddr = e_waddr[head];
    assign wr_mask  = e_mask[head];
    assign wr_data  = e_data[head];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            if (push) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
            end
            if (pop) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            e_waddr[tail] <= sb.alloc_waddr;
            e_mask[tail]  <= sb.alloc_mask;
            e_data[tail]  <= sb.alloc_data;
            e_tag[tail]   <= sb.alloc_tag;
        end
    end

    // Walk from head to tail so later stores overwrite earlier lanes.
    // A lane only moves to an entry that is not older than its holder.
    always_comb begin
        mrg_mask = '0;
        mrg_data = '0;
        walk_idx = head;
        for (int b = 0; b < LANES; b++) begin
            lane_tag[b] = '1;
        end
        for (int i = 0; i < SB_DEPTH; i++) begin
            walk_idx = head + i[SB_IDX_W-1:0];
            if (valid[walk_idx] && e_waddr[walk_idx] == sb.look_waddr) begin
                for (int b = 0; b < LANES; b++) begin
                    if (e_mask[walk_idx][b] && e_tag[walk_idx] <= lane_tag[b]) begin
                        mrg_mask[b]         = 1'b1;
                        mrg_data[8*b +: 8]  = e_data[walk_idx][8*b +: 8];
                        lane_tag[b]         = e_tag[walk_idx];
                    end
                end
            end
        end
    end

    // Registered alongside the RAM read
    always_ff @(posedge clk) begin
        if (reset) begin
            sb.look_mask <= '0;
        end else begin
            sb.look_mask <= mrg_mask;
        end
    end

    always_ff @(posedge clk) begin
        sb.look_data <= mrg_data;
    end

endmodule

`default_nettype wire
